// ==== gfx_bus_pkg.sv ====
// Bus request and response structs, response status enum and register address width
`default_nettype none

package gfx_bus_pkg;

  // Byte address width of the register window
  localparam int REG_ADR_W = 8;

  // Response status as seen by the master
  typedef enum logic {
    OKAY = 1'b0,
    ERR  = 1'b1
  } wb_status_e;

  // Request from the bus master
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [3:0]           sel;
    logic [REG_ADR_W-1:0] adr;
    logic [31:0]          dat;
  } wb_req_t;

  // Response back to the master
  typedef struct packed {
    logic       ack;
    wb_status_e status;
    logic [31:0] dat;
  } wb_resp_t;

endpackage

`default_nettype wire

// ==== gfx_reg_pkg.sv ====
// Register map and operation enums, bit positions, reset constants and render structs
`default_nettype none

package gfx_reg_pkg;

  // Register byte addresses
  typedef enum logic [7:0] {
    GFX_CONTROL       = 8'h00,
    GFX_STATUS        = 8'h04,
    GFX_TARGET_BASE   = 8'h08,
    GFX_TARGET_SIZE_X = 8'h0C,
    GFX_TARGET_SIZE_Y = 8'h10,
    GFX_CLIP0_X       = 8'h14,
    GFX_CLIP0_Y       = 8'h18,
    GFX_CLIP1_X       = 8'h1C,
    GFX_CLIP1_Y       = 8'h20,
    GFX_COLOR0        = 8'h24,
    GFX_ALPHA         = 8'h28,
    GFX_COLOR_COMP    = 8'h2C
  } gfx_reg_e;

  // Drawing operations, also the strobe bit order
  typedef enum logic [1:0] {
    OP_POINT,
    OP_RECT,
    OP_LINE,
    OP_TRI
  } gfx_op_e;

  // Control register layout
  localparam int CTRL_COLOR_DEPTH = 0;
  localparam int CTRL_BLENDING    = 2;
  localparam int CTRL_CLIPPING    = 3;
  localparam int CTRL_OP_BASE     = 8;

  // Status register layout
  localparam int STAT_BUSY      = 0;
  localparam int STAT_COUNT_LSB = 16;

  // Reset values
  localparam logic [31:0] CTRL_RESET       = 32'h0000_0001;
  localparam logic [15:0] GR_WIDTH         = 16'd1920;
  localparam logic [15:0] GR_HEIGHT        = 16'd1080;
  localparam logic [7:0]  ALPHA_RESET      = 8'hff;
  localparam logic [15:0] COLOR_COMP_RESET = 16'h1555;

  // Datapath and queue sizing
  localparam int POINT_W     = 16;
  localparam int MDW         = 256;
  localparam int QUEUE_DEPTH = 8;
  localparam int QUEUE_CNT_W = 4;

  // One queued register write
  typedef struct packed {
    gfx_reg_e    adr;
    logic [31:0] dat;
  } cmd_entry_t;

  // One strobe per gfx_op_e
  typedef logic [3:0] op_strobe_t;

  // Configuration seen by the drawing pipeline
  typedef struct packed {
    logic [31:0]        target_base;
    logic [POINT_W-1:0] target_size_x;
    logic [POINT_W-1:0] target_size_y;
    logic [POINT_W-1:0] clip_x0;
    logic [POINT_W-1:0] clip_y0;
    logic [POINT_W-1:0] clip_x1;
    logic [POINT_W-1:0] clip_y1;
    logic [31:0]        colour0;
    logic [7:0]         global_alpha;
    logic [1:0]         colour_depth;
    logic               blending_en;
    logic               clipping_en;
  } render_state_t;

  // Derived pixel format
  typedef struct packed {
    logic [5:0]  bpp;
    logic [5:0]  cbpp;
    logic        rmw;
    logic [15:0] coeff1;
  } pixel_fmt_t;

endpackage

`default_nettype wire

// ==== gfx_wb_slave.sv ====
// Bus slave with access decode, ack and error, write credits, read data and interrupt
`timescale 1ns/1ps
`default_nettype none

module gfx_wb_slave (
  input  wire                     wbs_clk_i,
  input  wire                     rst_i,
  input  wire gfx_bus_pkg::wb_req_t wb_req_i,
  input  wire                     pop_credit_i,
  input  wire [31:0]              rd_data_i,
  input  wire                     writer_sint_i,
  input  wire                     reader_sint_i,
  output gfx_bus_pkg::wb_resp_t   wb_resp_o,
  output logic                    push_o,
  output gfx_reg_pkg::cmd_entry_t cmd_o,
  output gfx_reg_pkg::gfx_reg_e   rd_adr_o,
  output logic                    inta_o
);

  logic [gfx_reg_pkg::QUEUE_CNT_W-1:0] credit_q;
  logic                                acc;
  logic                                full_sel;
  logic                                credit_ok;
  logic                                take;
  logic                                ack_q;
  logic                                err_q;
  logic [31:0]                         rd_dat_q;

  // Live access masked in the dead cycle after an ack
  assign acc       = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign full_sel  = (wb_req_i.sel == 4'hf);
  assign credit_ok = (credit_q != '0);

  // Full-width writes wait for a credit
  // Reads and byte-lane accesses complete at once
  assign take   = acc & (~wb_req_i.we | ~full_sel | credit_ok);
  assign push_o = acc & wb_req_i.we & full_sel & credit_ok;

  // Word aligned register address
  assign rd_adr_o  = gfx_reg_pkg::gfx_reg_e'({wb_req_i.adr[gfx_bus_pkg::REG_ADR_W-1:2], 2'b00});
  assign cmd_o.adr = rd_adr_o;
  assign cmd_o.dat = wb_req_i.dat;

  // Credits mirror free queue entries
  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      credit_q <= (gfx_reg_pkg::QUEUE_CNT_W)'(gfx_reg_pkg::QUEUE_DEPTH);
    end else begin
      credit_q <= credit_q + (gfx_reg_pkg::QUEUE_CNT_W)'(pop_credit_i)
                  - (gfx_reg_pkg::QUEUE_CNT_W)'(push_o);
    end
  end

  // Registered ack, status and interrupt
  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
      inta_o <= 1'b0;
    end else begin
      ack_q  <= take;
      err_q  <= take & ~full_sel;
      inta_o <= writer_sint_i | reader_sint_i;
    end
  end

  // Sample register value with the access
  always_ff @(posedge wbs_clk_i) begin
    if (take) begin
      rd_dat_q <= full_sel ? rd_data_i : 32'h0;
    end
  end

  assign wb_resp_o.ack    = ack_q;
  assign wb_resp_o.status = err_q ? gfx_bus_pkg::ERR : gfx_bus_pkg::OKAY;
  assign wb_resp_o.dat    = rd_dat_q;

  // Queue returns no more credits than were spent
  a_credit_max : assert property (@(posedge wbs_clk_i) disable iff (rst_i)
    credit_q <= gfx_reg_pkg::QUEUE_DEPTH);

endmodule

`default_nettype wire

// ==== gfx_cmd_queue.sv ====
// Synchronous command FIFO with fill count and credit return
`timescale 1ns/1ps
`default_nettype none

module gfx_cmd_queue (
  input  wire                                  wbs_clk_i,
  input  wire                                  rst_i,
  input  wire                                  push_i,
  input  wire gfx_reg_pkg::cmd_entry_t         cmd_i,
  input  wire                                  pop_i,
  output gfx_reg_pkg::cmd_entry_t              head_o,
  output logic                                 not_empty_o,
  output logic                                 pop_credit_o,
  output logic [gfx_reg_pkg::QUEUE_CNT_W-1:0]  count_o
);

  // Storage for queued writes
  gfx_reg_pkg::cmd_entry_t              mem [gfx_reg_pkg::QUEUE_DEPTH];
  logic [gfx_reg_pkg::QUEUE_CNT_W-2:0]  wr_ptr_q;
  logic [gfx_reg_pkg::QUEUE_CNT_W-2:0]  rd_ptr_q;
  logic [gfx_reg_pkg::QUEUE_CNT_W-1:0]  count_q;

  always_ff @(posedge wbs_clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= cmd_i;
    end
  end

  // Pointers wrap on the power of two depth
  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      pop_credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q      <= count_q + (gfx_reg_pkg::QUEUE_CNT_W)'(push_i)
                      - (gfx_reg_pkg::QUEUE_CNT_W)'(pop_i);
      // One credit back per freed entry
      pop_credit_o <= pop_i;
    end
  end

  // Head is valid whenever not empty
  assign head_o      = mem[rd_ptr_q];
  assign not_empty_o = (count_q != '0);
  assign count_o     = count_q;

  // Credit scheme keeps the slave off a full queue
  a_no_overflow : assert property (@(posedge wbs_clk_i) disable iff (rst_i)
    push_i |-> count_q != gfx_reg_pkg::QUEUE_DEPTH);

  a_no_underflow : assert property (@(posedge wbs_clk_i) disable iff (rst_i)
    pop_i |-> count_q != '0);

endmodule

`default_nettype wire

// ==== gfx_reg_file.sv ====
// Config registers, queued write apply, op strobes, busy FSM, status word and read mux
`timescale 1ns/1ps
`default_nettype none

module gfx_reg_file (
  input  wire                                 wbs_clk_i,
  input  wire                                 rst_i,
  input  wire gfx_reg_pkg::cmd_entry_t        head_i,
  input  wire                                 not_empty_i,
  input  wire [gfx_reg_pkg::QUEUE_CNT_W-1:0]  count_i,
  input  wire                                 pipeline_ack_i,
  input  wire gfx_reg_pkg::gfx_reg_e          rd_adr_i,
  output logic                                pop_o,
  output logic [31:0]                         rd_data_o,
  output gfx_reg_pkg::render_state_t          state_o,
  output gfx_reg_pkg::op_strobe_t             op_o,
  output logic [15:0]                         colour_comp_o
);

  typedef enum logic {
    IDLE,
    BUSY
  } fsm_e;

  fsm_e                       fsm_q;
  gfx_reg_pkg::render_state_t st_q;
  gfx_reg_pkg::op_strobe_t    op_q;
  logic [15:0]                comp_q;
  logic                       busy;
  logic [31:0]                status_w;

  // Drain only when idle and not in a strobe cycle
  assign pop_o = not_empty_i & (fsm_q == IDLE) & (op_q == '0);

  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      st_q                <= '0;
      st_q.target_size_x  <= gfx_reg_pkg::GR_WIDTH;
      st_q.target_size_y  <= gfx_reg_pkg::GR_HEIGHT;
      st_q.clip_x1        <= gfx_reg_pkg::GR_WIDTH;
      st_q.clip_y1        <= gfx_reg_pkg::GR_HEIGHT;
      st_q.global_alpha   <= gfx_reg_pkg::ALPHA_RESET;
      st_q.colour_depth   <= gfx_reg_pkg::CTRL_RESET[gfx_reg_pkg::CTRL_COLOR_DEPTH +: 2];
      st_q.blending_en    <= gfx_reg_pkg::CTRL_RESET[gfx_reg_pkg::CTRL_BLENDING];
      st_q.clipping_en    <= gfx_reg_pkg::CTRL_RESET[gfx_reg_pkg::CTRL_CLIPPING];
      comp_q              <= gfx_reg_pkg::COLOR_COMP_RESET;
      op_q                <= '0;
    end else begin
      // Op bits self clear after one cycle
      op_q <= '0;
      if (pop_o) begin
        case (head_i.adr)
          gfx_reg_pkg::GFX_CONTROL: begin
            st_q.colour_depth <= head_i.dat[gfx_reg_pkg::CTRL_COLOR_DEPTH +: 2];
            st_q.blending_en  <= head_i.dat[gfx_reg_pkg::CTRL_BLENDING];
            st_q.clipping_en  <= head_i.dat[gfx_reg_pkg::CTRL_CLIPPING];
            op_q              <= head_i.dat[gfx_reg_pkg::CTRL_OP_BASE +: 4];
          end
          gfx_reg_pkg::GFX_TARGET_BASE:   st_q.target_base   <= head_i.dat;
          gfx_reg_pkg::GFX_TARGET_SIZE_X: st_q.target_size_x <= head_i.dat[15:0];
          gfx_reg_pkg::GFX_TARGET_SIZE_Y: st_q.target_size_y <= head_i.dat[15:0];
          gfx_reg_pkg::GFX_CLIP0_X:       st_q.clip_x0       <= head_i.dat[15:0];
          gfx_reg_pkg::GFX_CLIP0_Y:       st_q.clip_y0       <= head_i.dat[15:0];
          gfx_reg_pkg::GFX_CLIP1_X:       st_q.clip_x1       <= head_i.dat[15:0];
          gfx_reg_pkg::GFX_CLIP1_Y:       st_q.clip_y1       <= head_i.dat[15:0];
          gfx_reg_pkg::GFX_COLOR0:        st_q.colour0       <= head_i.dat;
          gfx_reg_pkg::GFX_ALPHA:         st_q.global_alpha  <= head_i.dat[7:0];
          gfx_reg_pkg::GFX_COLOR_COMP:    comp_q             <= head_i.dat[15:0];
          // Status and unmapped writes dropped
          default: ;
        endcase
      end
    end
  end

  // Busy from strobe until pipeline ack
  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      fsm_q <= IDLE;
    end else begin
      case (fsm_q)
        IDLE:    if (op_q != '0) fsm_q <= BUSY;
        BUSY:    if (pipeline_ack_i) fsm_q <= IDLE;
        default: fsm_q <= IDLE;
      endcase
    end
  end

  // Strobe cycle already counts as busy
  assign busy = (fsm_q == BUSY) | (op_q != '0);

  always_comb begin
    status_w = '0;
    status_w[gfx_reg_pkg::STAT_BUSY] = busy;
    status_w[gfx_reg_pkg::STAT_COUNT_LSB +: gfx_reg_pkg::QUEUE_CNT_W] = count_i;
  end

  // Read mux where reserved bits and holes read 0
  always_comb begin
    rd_data_o = '0;
    case (rd_adr_i)
      gfx_reg_pkg::GFX_CONTROL: begin
        rd_data_o[gfx_reg_pkg::CTRL_COLOR_DEPTH +: 2] = st_q.colour_depth;
        rd_data_o[gfx_reg_pkg::CTRL_BLENDING]         = st_q.blending_en;
        rd_data_o[gfx_reg_pkg::CTRL_CLIPPING]         = st_q.clipping_en;
      end
      gfx_reg_pkg::GFX_STATUS:        rd_data_o = status_w;
      gfx_reg_pkg::GFX_TARGET_BASE:   rd_data_o = st_q.target_base;
      gfx_reg_pkg::GFX_TARGET_SIZE_X: rd_data_o = 32'(st_q.target_size_x);
      gfx_reg_pkg::GFX_TARGET_SIZE_Y: rd_data_o = 32'(st_q.target_size_y);
      gfx_reg_pkg::GFX_CLIP0_X:       rd_data_o = 32'(st_q.clip_x0);
      gfx_reg_pkg::GFX_CLIP0_Y:       rd_data_o = 32'(st_q.clip_y0);
      gfx_reg_pkg::GFX_CLIP1_X:       rd_data_o = 32'(st_q.clip_x1);
      gfx_reg_pkg::GFX_CLIP1_Y:       rd_data_o = 32'(st_q.clip_y1);
      gfx_reg_pkg::GFX_COLOR0:        rd_data_o = st_q.colour0;
      gfx_reg_pkg::GFX_ALPHA:         rd_data_o = 32'(st_q.global_alpha);
      gfx_reg_pkg::GFX_COLOR_COMP:    rd_data_o = 32'(comp_q);
      default: ;
    endcase
  end

  assign state_o       = st_q;
  assign op_o          = op_q;
  assign colour_comp_o = comp_q;

  // No new operation while the pipeline still runs
  a_strobe_idle : assert property (@(posedge wbs_clk_i) disable iff (rst_i)
    (op_q != '0) |-> (fsm_q == IDLE));

endmodule

`default_nettype wire

// ==== gfx_pixel_format.sv ====
// Two-stage pixel format pipeline from the colour composition register
`timescale 1ns/1ps
`default_nettype none

module gfx_pixel_format (
  input  wire                     wbs_clk_i,
  input  wire [15:0]              colour_comp_i,
  output gfx_reg_pkg::pixel_fmt_t fmt_o
);

  logic [3:0] pad_q;
  logic [3:0] red_q;
  logic [3:0] green_q;
  logic [3:0] blue_q;
  logic [5:0] bpp_w;
  logic [5:0] cbpp_w;

  // Stage 1 splits the pad/r/g/b widths
  always_ff @(posedge wbs_clk_i) begin
    pad_q   <= colour_comp_i[15:12];
    red_q   <= colour_comp_i[11:8];
    green_q <= colour_comp_i[7:4];
    blue_q  <= colour_comp_i[3:0];
  end

  // Sums are stored minus one
  assign bpp_w  = 6'(pad_q) + 6'(red_q) + 6'(green_q) + 6'(blue_q) - 6'd1;
  assign cbpp_w = 6'(red_q) + 6'(green_q) + 6'(blue_q) - 6'd1;

  // Stage 2 takes all fields from stage 1 so they land together
  always_ff @(posedge wbs_clk_i) begin
    fmt_o.bpp    <= bpp_w;
    fmt_o.cbpp   <= cbpp_w;
    // Partial bytes need read-modify-write
    fmt_o.rmw    <= |bpp_w[2:0];
    // Strip reciprocal scale
    fmt_o.coeff1 <= 16'(bpp_w * (65536 / gfx_reg_pkg::MDW));
  end

endmodule

`default_nettype wire

// ==== gfx_wbs_top.sv ====
// Top level joining bus slave, command queue, register file and pixel format unit
`timescale 1ns/1ps
`default_nettype none

module gfx_wbs_top (
  input  wire                         wbs_clk_i,
  input  wire                         rst_i,
  input  wire gfx_bus_pkg::wb_req_t   wb_req_i,
  input  wire                         pipeline_ack_i,
  input  wire                         writer_sint_i,
  input  wire                         reader_sint_i,
  output gfx_bus_pkg::wb_resp_t       wb_resp_o,
  output logic                        inta_o,
  output gfx_reg_pkg::render_state_t  state_o,
  output gfx_reg_pkg::op_strobe_t     op_o,
  output gfx_reg_pkg::pixel_fmt_t     fmt_o
);

  logic                                push;
  logic                                pop;
  logic                                pop_credit;
  logic                                not_empty;
  gfx_reg_pkg::cmd_entry_t             cmd;
  gfx_reg_pkg::cmd_entry_t             head;
  gfx_reg_pkg::gfx_reg_e               rd_adr;
  logic [31:0]                         rd_data;
  logic [gfx_reg_pkg::QUEUE_CNT_W-1:0] count;
  logic [15:0]                         colour_comp;

  gfx_wb_slave u_slave (
    .wbs_clk_i     (wbs_clk_i),
    .rst_i         (rst_i),
    .wb_req_i      (wb_req_i),
    .pop_credit_i  (pop_credit),
    .rd_data_i     (rd_data),
    .writer_sint_i (writer_sint_i),
    .reader_sint_i (reader_sint_i),
    .wb_resp_o     (wb_resp_o),
    .push_o        (push),
    .cmd_o         (cmd),
    .rd_adr_o      (rd_adr),
    .inta_o        (inta_o)
  );

  gfx_cmd_queue u_queue (
    .wbs_clk_i    (wbs_clk_i),
    .rst_i        (rst_i),
    .push_i       (push),
    .cmd_i        (cmd),
    .pop_i        (pop),
    .head_o       (head),
    .not_empty_o  (not_empty),
    .pop_credit_o (pop_credit),
    .count_o      (count)
  );

  gfx_reg_file u_regs (
    .wbs_clk_i      (wbs_clk_i),
    .rst_i          (rst_i),
    .head_i         (head),
    .not_empty_i    (not_empty),
    .count_i        (count),
    .pipeline_ack_i (pipeline_ack_i),
    .rd_adr_i       (rd_adr),
    .pop_o          (pop),
    .rd_data_o      (rd_data),
    .state_o        (state_o),
    .op_o           (op_o),
    .colour_comp_o  (colour_comp)
  );

  gfx_pixel_format u_fmt (
    .wbs_clk_i     (wbs_clk_i),
    .colour_comp_i (colour_comp),
    .fmt_o         (fmt_o)
  );

endmodule

`default_nettype wire

// ==== gfx_wbs_tb.sv ====
// Testbench for gfx_wbs_top with clock, reset, bus tasks, stimulus table and checks
`timescale 1ns/1ps
`default_nettype none

module gfx_wbs_tb;

  localparam int TIMEOUT = 200;
  localparam int ROWS    = 14;

  // Table row of address, readable bit mask and state_o field flag
  typedef struct packed {
    logic [7:0]  adr;
    logic [31:0] mask;
    logic        chk;
  } row_t;

  logic                       wbs_clk;
  logic                       rst;
  gfx_bus_pkg::wb_req_t       req;
  gfx_bus_pkg::wb_resp_t      resp;
  logic                       pipeline_ack;
  logic                       writer_sint;
  logic                       reader_sint;
  logic                       inta;
  gfx_reg_pkg::render_state_t state;
  gfx_reg_pkg::op_strobe_t    op;
  gfx_reg_pkg::pixel_fmt_t    fmt;

  row_t                       rows [ROWS];
  logic [31:0]                wdat [ROWS];
  logic [31:0]                exp_rd [ROWS];
  integer                     seed = 32'hd2cc_37c1;
  int                         value_errs = 0;
  int                         timeout_errs = 0;
  int                         rect_cnt = 0;
  int                         other_cnt = 0;
  int                         i;
  logic [31:0]                rdat;
  logic                       got;
  gfx_bus_pkg::wb_status_e    st;
  logic [15:0]                comp;

  gfx_wbs_top dut0 (
    .wbs_clk_i      (wbs_clk),
    .rst_i          (rst),
    .wb_req_i       (req),
    .pipeline_ack_i (pipeline_ack),
    .writer_sint_i  (writer_sint),
    .reader_sint_i  (reader_sint),
    .wb_resp_o      (resp),
    .inta_o         (inta),
    .state_o        (state),
    .op_o           (op),
    .fmt_o          (fmt)
  );

  // 40 ns period
  always #20 wbs_clk = ~wbs_clk;

  // Count strobe cycles sampled mid-cycle
  always @(negedge wbs_clk) begin
    if (op[gfx_reg_pkg::OP_RECT]) rect_cnt++;
    if ((op & ~(4'b1 << gfx_reg_pkg::OP_RECT)) != 4'h0) other_cnt++;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      value_errs++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Drive a request on the falling edge with one idle cycle after the last ack
  task automatic start_access(input logic we, input logic [3:0] sel, input logic [7:0] adr,
                              input logic [31:0] dat);
    @(negedge wbs_clk);
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.sel = sel;
    req.adr = adr;
    req.dat = dat;
  endtask

  // Bounded wait for ack before releasing the bus
  task automatic wait_ack(input int limit, output logic ok, output gfx_bus_pkg::wb_status_e s,
                          output logic [31:0] d);
    int n;
    ok = 1'b0;
    n  = 0;
    s  = gfx_bus_pkg::OKAY;
    d  = 32'h0;
    while (!ok && n < limit) begin
      @(negedge wbs_clk);
      n++;
      if (resp.ack) begin
        ok      = 1'b1;
        s       = resp.status;
        d       = resp.dat;
        req.cyc = 1'b0;
        req.stb = 1'b0;
        req.we  = 1'b0;
      end
    end
  endtask

  task automatic bus_access(input logic we, input logic [3:0] sel, input logic [7:0] adr,
                            input logic [31:0] dat, output gfx_bus_pkg::wb_status_e s,
                            output logic [31:0] d);
    logic ok;
    start_access(we, sel, adr, dat);
    wait_ack(TIMEOUT, ok, s, d);
    assert (ok) else begin
      timeout_errs++;
      $display("Bus access to address %h was never acknowledged", adr);
      req = '0;
    end
  endtask

  task automatic bus_write(input logic [7:0] adr, input logic [31:0] dat);
    gfx_bus_pkg::wb_status_e s;
    logic [31:0]             d;
    bus_access(1'b1, 4'hf, adr, dat, s, d);
    check_value("wb_resp_o.status", gfx_bus_pkg::OKAY, s);
  endtask

  task automatic bus_read(input logic [7:0] adr, output logic [31:0] d);
    gfx_bus_pkg::wb_status_e s;
    bus_access(1'b0, 4'hf, adr, 32'h0, s, d);
    check_value("wb_resp_o.status", gfx_bus_pkg::OKAY, s);
  endtask

  task automatic read_expect(input logic [7:0] adr, input logic [31:0] exp);
    logic [31:0] d;
    bus_read(adr, d);
    check_value($sformatf("wb_resp_o.dat @%h", adr), exp, d);
  endtask

  // Poll status until queue empty and not busy
  task automatic wait_idle();
    logic [31:0] s;
    logic        idle;
    int          n;
    idle = 1'b0;
    n    = 0;
    while (!idle && n < TIMEOUT) begin
      bus_read(gfx_reg_pkg::GFX_STATUS, s);
      idle = !s[gfx_reg_pkg::STAT_BUSY] &&
             (s[gfx_reg_pkg::STAT_COUNT_LSB +: gfx_reg_pkg::QUEUE_CNT_W] == '0);
      n++;
    end
    assert (idle) else begin
      timeout_errs++;
      $display("Register file did not become idle in time");
    end
  endtask

  // state_o field behind a register address placed as it reads back
  function automatic logic [31:0] state_field(input logic [7:0] adr,
                                              input gfx_reg_pkg::render_state_t s);
    case (adr)
      gfx_reg_pkg::GFX_CONTROL:       return {28'h0, s.clipping_en, s.blending_en, s.colour_depth};
      gfx_reg_pkg::GFX_TARGET_BASE:   return s.target_base;
      gfx_reg_pkg::GFX_TARGET_SIZE_X: return {16'h0, s.target_size_x};
      gfx_reg_pkg::GFX_TARGET_SIZE_Y: return {16'h0, s.target_size_y};
      gfx_reg_pkg::GFX_CLIP0_X:       return {16'h0, s.clip_x0};
      gfx_reg_pkg::GFX_CLIP0_Y:       return {16'h0, s.clip_y0};
      gfx_reg_pkg::GFX_CLIP1_X:       return {16'h0, s.clip_x1};
      gfx_reg_pkg::GFX_CLIP1_Y:       return {16'h0, s.clip_y1};
      gfx_reg_pkg::GFX_COLOR0:        return s.colour0;
      gfx_reg_pkg::GFX_ALPHA:         return {24'h0, s.global_alpha};
      default:                        return 32'h0;
    endcase
  endfunction

  task automatic check_reg(input int idx);
    read_expect(rows[idx].adr, exp_rd[idx]);
    if (rows[idx].chk) begin
      check_value($sformatf("state_o @%h", rows[idx].adr), exp_rd[idx],
                  state_field(rows[idx].adr, state));
    end
  endtask

  // Expected format from pad/red/green/blue widths
  task automatic check_fmt(input logic [15:0] c);
    logic [5:0]  bpp;
    logic [5:0]  cbpp;
    logic [15:0] coeff;
    bpp   = 6'(c[15:12]) + 6'(c[11:8]) + 6'(c[7:4]) + 6'(c[3:0]) - 6'd1;
    cbpp  = 6'(c[11:8]) + 6'(c[7:4]) + 6'(c[3:0]) - 6'd1;
    coeff = 16'(bpp) * 16'(65536 / gfx_reg_pkg::MDW);
    check_value("fmt_o.bpp", 32'(bpp), 32'(fmt.bpp));
    check_value("fmt_o.cbpp", 32'(cbpp), 32'(fmt.cbpp));
    check_value("fmt_o.rmw", 32'(|bpp[2:0]), 32'(fmt.rmw));
    check_value("fmt_o.coeff1", 32'(coeff), 32'(fmt.coeff1));
  endtask

  initial begin
    wbs_clk      = 1'b0;
    rst          = 1'b1;
    req          = '0;
    pipeline_ack = 1'b0;
    writer_sint  = 1'b0;
    reader_sint  = 1'b0;
    rows = '{
      {gfx_reg_pkg::GFX_CONTROL,       32'h0000_000f, 1'b1},
      {gfx_reg_pkg::GFX_STATUS,        32'h0000_0000, 1'b0},
      {gfx_reg_pkg::GFX_TARGET_BASE,   32'hffff_ffff, 1'b1},
      {gfx_reg_pkg::GFX_TARGET_SIZE_X, 32'h0000_ffff, 1'b1},
      {gfx_reg_pkg::GFX_TARGET_SIZE_Y, 32'h0000_ffff, 1'b1},
      {gfx_reg_pkg::GFX_CLIP0_X,       32'h0000_ffff, 1'b1},
      {gfx_reg_pkg::GFX_CLIP0_Y,       32'h0000_ffff, 1'b1},
      {gfx_reg_pkg::GFX_CLIP1_X,       32'h0000_ffff, 1'b1},
      {gfx_reg_pkg::GFX_CLIP1_Y,       32'h0000_ffff, 1'b1},
      {gfx_reg_pkg::GFX_COLOR0,        32'hffff_ffff, 1'b1},
      {gfx_reg_pkg::GFX_ALPHA,         32'h0000_00ff, 1'b1},
      {gfx_reg_pkg::GFX_COLOR_COMP,    32'h0000_ffff, 1'b0},
      {8'h30,                          32'h0000_0000, 1'b0},
      {8'hfc,                          32'h0000_0000, 1'b0}
    };
    // 4 cycles of reset released on a falling edge
    repeat (4) @(negedge wbs_clk);
    rst = 1'b0;

    // Reset values
    read_expect(gfx_reg_pkg::GFX_CONTROL, 32'h1);
    read_expect(gfx_reg_pkg::GFX_STATUS, 32'h0);
    read_expect(gfx_reg_pkg::GFX_TARGET_SIZE_X, 32'd1920);
    read_expect(gfx_reg_pkg::GFX_TARGET_SIZE_Y, 32'd1080);
    read_expect(gfx_reg_pkg::GFX_CLIP1_X, 32'd1920);
    read_expect(gfx_reg_pkg::GFX_CLIP1_Y, 32'd1080);
    read_expect(gfx_reg_pkg::GFX_ALPHA, 32'hff);
    read_expect(gfx_reg_pkg::GFX_COLOR_COMP, 32'h1555);
    check_value("fmt_o.bpp", 32'd15, 32'(fmt.bpp));
    check_value("fmt_o.cbpp", 32'd14, 32'(fmt.cbpp));
    check_value("fmt_o.rmw", 32'd1, 32'(fmt.rmw));
    check_value("fmt_o.coeff1", 32'd3840, 32'(fmt.coeff1));

    // Table pass over one register at a time
    for (i = 0; i < ROWS; i++) begin
      wdat[i] = $random(seed);
      // Keep op bits clear so no operation starts
      if (rows[i].adr == gfx_reg_pkg::GFX_CONTROL) wdat[i][gfx_reg_pkg::CTRL_OP_BASE +: 4] = 4'h0;
      exp_rd[i] = wdat[i] & rows[i].mask;
      bus_write(rows[i].adr, wdat[i]);
      wait_idle();
      check_reg(i);
    end

    // Rect operation followed by a queue fill while busy
    rect_cnt  = 0;
    other_cnt = 0;
    bus_write(gfx_reg_pkg::GFX_CONTROL, 32'h1 | (32'h1 << (gfx_reg_pkg::CTRL_OP_BASE + 1)));
    bus_read(gfx_reg_pkg::GFX_STATUS, rdat);
    check_value("status busy", 32'h1, 32'(rdat[gfx_reg_pkg::STAT_BUSY]));
    for (i = 2; i < 10; i++) begin
      wdat[i]   = $random(seed);
      exp_rd[i] = wdat[i] & rows[i].mask;
      bus_write(rows[i].adr, wdat[i]);
    end
    // Ninth write has no credit until the pipeline acks
    wdat[10]   = $random(seed);
    exp_rd[10] = wdat[10] & rows[10].mask;
    start_access(1'b1, 4'hf, rows[10].adr, wdat[10]);
    wait_ack(20, got, st, rdat);
    assert (!got) else begin
      value_errs++;
      $display("Write into a full queue was acknowledged before the pipeline ack");
    end
    @(negedge wbs_clk);
    pipeline_ack = 1'b1;
    @(negedge wbs_clk);
    pipeline_ack = 1'b0;
    wait_ack(TIMEOUT, got, st, rdat);
    assert (got) else begin
      timeout_errs++;
      $display("Blocked write was not acknowledged after the pipeline ack");
      req = '0;
    end
    wait_idle();
    check_value("rect strobe cycles", 32'd1, 32'(rect_cnt));
    check_value("other strobe cycles", 32'd0, 32'(other_cnt));
    for (i = 2; i < 11; i++) begin
      check_reg(i);
    end
    // Op bits of the rect write read back as 0
    read_expect(gfx_reg_pkg::GFX_CONTROL, 32'h1);

    // Partial sel gives ERR and no update
    bus_access(1'b1, 4'h3, gfx_reg_pkg::GFX_TARGET_SIZE_X, 32'hdead_beef, st, rdat);
    check_value("wb_resp_o.status", gfx_bus_pkg::ERR, st);
    bus_access(1'b0, 4'h3, gfx_reg_pkg::GFX_TARGET_SIZE_X, 32'h0, st, rdat);
    check_value("wb_resp_o.status", gfx_bus_pkg::ERR, st);
    wait_idle();
    check_reg(3);

    // Random colour compositions
    for (i = 0; i < 4; i++) begin
      comp = 16'($random(seed));
      bus_write(gfx_reg_pkg::GFX_COLOR_COMP, 32'(comp));
      wait_idle();
      // Pipeline latency of 2 cycles
      repeat (2) @(negedge wbs_clk);
      check_fmt(comp);
    end

    // Interrupt follows either error input
    writer_sint = 1'b1;
    @(negedge wbs_clk);
    check_value("inta_o", 32'h1, 32'(inta));
    writer_sint = 1'b0;
    reader_sint = 1'b1;
    @(negedge wbs_clk);
    check_value("inta_o", 32'h1, 32'(inta));
    reader_sint = 1'b0;
    @(negedge wbs_clk);
    check_value("inta_o", 32'h0, 32'(inta));

    $display("Checks done: %0d value errors, %0d timeouts", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
gfx_bus_pkg.sv
gfx_reg_pkg.sv
gfx_wb_slave.sv
gfx_cmd_queue.sv
gfx_reg_file.sv
gfx_pixel_format.sv
gfx_wbs_top.sv
gfx_wbs_tb.sv
